// File: flist.f
hdl/sprite_pkg.sv
hdl/oam_ram.sv
hdl/oam_scan.sv
hdl/sprite_store.sv
hdl/sprite_x_matchers.sv
hdl/sprite_line_top.sv
testbench/tb_clock.sv
testbench/sprite_line_props.sv
testbench/sprite_line_tb.sv

// File: hdl/oam_ram.sv
`timescale 1ns/1ns

module oam_ram import sprite_pkg::*; (
		input  logic                     clk,
		input  logic                     cpu_we,
		input  logic [oam_addr_bits-1:0] cpu_addr,
		input  logic [7:0]               cpu_wdata,
		input  logic [index_bits-1:0]    scan_addr,
		output logic [7:0]               scan_y,
		output logic [7:0]               scan_x
	);

	logic [7:0] y_mem [oam_entries];
	logic [7:0] x_mem [oam_entries];
	logic [index_bits-1:0] cpu_entry;

	assign cpu_entry = cpu_addr[oam_addr_bits-1:1];

	// Writes past the last object are dropped
	always_ff @(posedge clk) begin
		if (cpu_we && cpu_entry < index_bits'(oam_entries)) begin
			if (cpu_addr[0])
				x_mem[cpu_entry] <= cpu_wdata;
			else
				y_mem[cpu_entry] <= cpu_wdata;
		end
	end

	// Scanner sees both bytes of an entry one cycle after the address
	always_ff @(posedge clk) begin
		scan_y <= y_mem[scan_addr];
		scan_x <= x_mem[scan_addr];
	end

endmodule

// File: hdl/oam_scan.sv
`timescale 1ns/1ns

module oam_scan import sprite_pkg::*; (
		input  logic                  clk,
		input  logic                  reset,
		input  logic                  line_start,
		input  logic [7:0]            line,
		input  logic                  tall,
		output logic [index_bits-1:0] scan_addr,
		input  logic [7:0]            scan_y,
		input  logic [7:0]            scan_x,
		output logic                  store_clear,
		output logic                  store_load,
		output logic [7:0]            store_x,
		output logic [index_bits-1:0] store_index,
		output logic                  scan_done
	);

	scan_state_t state;
	logic [7:0] line_q;
	logic tall_q;
	logic [index_bits-1:0] data_idx;	// Entry whose bytes are on scan_y and scan_x
	logic [slot_bits-1:0] loaded;
	logic [8:0] row;
	logic covers;

	// Rows above the sprite wrap to large values, so one unsigned compare does both bounds
	always_comb begin
		row = {1'b0, line_q} + 9'(y_offset) - {1'b0, scan_y};
		covers = row < (tall_q ? 9'(tall_height) : 9'(short_height));
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= s_idle;
			scan_addr <= '0;
			data_idx <= '0;
			loaded <= '0;
			store_clear <= 1'b0;
			store_load <= 1'b0;
			scan_done <= 1'b0;
		end else begin
			store_clear <= 1'b0;
			store_load <= 1'b0;
			scan_done <= 1'b0;
			if (line_start) begin	// A new line restarts the walk from any state
				state <= s_read;
				scan_addr <= '0;
				loaded <= '0;
				store_clear <= 1'b1;
			end else begin
				case (state)
					s_read: begin
						scan_addr <= scan_addr + 1'b1;
						data_idx <= '0;
						state <= s_test;
					end
					s_test: begin
						if (covers && loaded < slot_bits'(sprite_slots)) begin
							store_load <= 1'b1;
							loaded <= loaded + 1'b1;
						end
						if (scan_addr != index_bits'(oam_entries - 1))
							scan_addr <= scan_addr + 1'b1;
						data_idx <= data_idx + 1'b1;
						if (data_idx == index_bits'(oam_entries - 1))
							state <= s_done;
					end
					s_done: begin
						scan_done <= 1'b1;
						state <= s_idle;
					end
					default: state <= s_idle;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (line_start) begin
			line_q <= line;
			tall_q <= tall;
		end
		store_x <= scan_x;
		store_index <= data_idx;
	end

endmodule

// File: hdl/sprite_line_top.sv
`timescale 1ns/1ns

module sprite_line_top import sprite_pkg::*; (
		input  logic                     clk,
		input  logic                     reset,
		input  logic                     cpu_we,
		input  logic [oam_addr_bits-1:0] cpu_addr,
		input  logic [7:0]               cpu_wdata,
		input  logic [slot_bits-1:0]     cpu_slot_sel,
		output logic [7:0]               cpu_slot_x,
		input  logic [7:0]               line,
		input  logic                     tall,
		input  logic                     line_start,
		output logic                     hit,
		output logic [index_bits-1:0]    hit_index,
		output logic [7:0]               hit_x,
		output logic                     line_done
	);

	logic [index_bits-1:0] scan_addr;
	logic [7:0] scan_y;
	logic [7:0] scan_x;
	logic store_clear;
	logic store_load;
	logic [7:0] store_x;
	logic [index_bits-1:0] store_index;
	logic scan_done;
	logic [sprite_slots-1:0] retire_slot;
	logic [sprite_slots-1:0] slot_valid;
	logic [sprite_slots-1:0][7:0] slot_x;
	logic [sprite_slots-1:0][index_bits-1:0] slot_index;

	oam_ram i_oam_ram (
		.clk(clk),
		.cpu_we(cpu_we),
		.cpu_addr(cpu_addr),
		.cpu_wdata(cpu_wdata),
		.scan_addr(scan_addr),
		.scan_y(scan_y),
		.scan_x(scan_x)
	);

	oam_scan i_oam_scan (
		.clk(clk),
		.reset(reset),
		.line_start(line_start),
		.line(line),
		.tall(tall),
		.scan_addr(scan_addr),
		.scan_y(scan_y),
		.scan_x(scan_x),
		.store_clear(store_clear),
		.store_load(store_load),
		.store_x(store_x),
		.store_index(store_index),
		.scan_done(scan_done)
	);

	sprite_store i_sprite_store (
		.clk(clk),
		.reset(reset),
		.store_clear(store_clear),
		.store_load(store_load),
		.store_x(store_x),
		.store_index(store_index),
		.retire_slot(retire_slot),
		.slot_valid(slot_valid),
		.slot_x(slot_x),
		.slot_index(slot_index),
		.cpu_slot_sel(cpu_slot_sel),
		.cpu_slot_x(cpu_slot_x)
	);

	sprite_x_matchers i_sprite_x_matchers (
		.clk(clk),
		.reset(reset),
		.scan_done(scan_done),
		.slot_valid(slot_valid),
		.slot_x(slot_x),
		.slot_index(slot_index),
		.retire_slot(retire_slot),
		.hit(hit),
		.hit_index(hit_index),
		.hit_x(hit_x),
		.line_done(line_done)
	);

endmodule

// File: hdl/sprite_pkg.sv
package sprite_pkg;

	// Object memory geometry
	localparam int oam_entries   = 40;
	localparam int oam_addr_bits = 7;	// Even bytes hold Y, odd bytes hold X
	localparam int index_bits    = 6;

	// Per line sprite store
	localparam int sprite_slots = 10;
	localparam int slot_bits    = 4;

	// Line geometry
	localparam int line_pixels  = 168;	// X values at or above this never reach the counter
	localparam int y_offset     = 16;
	localparam int short_height = 8;
	localparam int tall_height  = 16;

	typedef enum logic [1:0] {
		s_idle,
		s_read,
		s_test,
		s_done
	} scan_state_t;

	typedef enum logic [1:0] {
		m_idle,
		m_run,
		m_finished
	} match_state_t;

endpackage

// File: hdl/sprite_store.sv
`timescale 1ns/1ns

module sprite_store import sprite_pkg::*; (
		input  logic                                    clk,
		input  logic                                    reset,
		input  logic                                    store_clear,
		input  logic                                    store_load,
		input  logic [7:0]                              store_x,
		input  logic [index_bits-1:0]                   store_index,
		input  logic [sprite_slots-1:0]                 retire_slot,
		output logic [sprite_slots-1:0]                 slot_valid,
		output logic [sprite_slots-1:0][7:0]            slot_x,
		output logic [sprite_slots-1:0][index_bits-1:0] slot_index,
		input  logic [slot_bits-1:0]                    cpu_slot_sel,
		output logic [7:0]                              cpu_slot_x
	);

	logic [slot_bits-1:0] fill_ptr;
	logic room;

	assign room = fill_ptr < slot_bits'(sprite_slots);

	always_ff @(posedge clk) begin
		if (reset) begin
			fill_ptr <= '0;
			slot_valid <= '0;
		end else if (store_clear) begin
			fill_ptr <= '0;
			slot_valid <= '0;
		end else begin
			for (int i = 0; i < sprite_slots; i++) begin
				if (retire_slot[i])
					slot_valid[i] <= 1'b0;
				else if (store_load && room && fill_ptr == slot_bits'(i))
					slot_valid[i] <= 1'b1;
			end
			if (store_load && room)
				fill_ptr <= fill_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < sprite_slots; i++) begin
			if (store_load && room && fill_ptr == slot_bits'(i)) begin
				slot_x[i] <= store_x;
				slot_index[i] <= store_index;
			end
		end
	end

	// Empty slots and selections past the last slot read as 0xFF
	always_comb begin
		cpu_slot_x = 8'hff;
		for (int i = 0; i < sprite_slots; i++) begin
			if (cpu_slot_sel == slot_bits'(i) && slot_valid[i])
				cpu_slot_x = slot_x[i];
		end
	end

endmodule

// File: hdl/sprite_x_matchers.sv
`timescale 1ns/1ns

module sprite_x_matchers import sprite_pkg::*; (
		input  logic                                    clk,
		input  logic                                    reset,
		input  logic                                    scan_done,
		input  logic [sprite_slots-1:0]                 slot_valid,
		input  logic [sprite_slots-1:0][7:0]            slot_x,
		input  logic [sprite_slots-1:0][index_bits-1:0] slot_index,
		output logic [sprite_slots-1:0]                 retire_slot,
		output logic                                    hit,
		output logic [index_bits-1:0]                   hit_index,
		output logic [7:0]                              hit_x,
		output logic                                    line_done
	);

	match_state_t state;
	logic [7:0] counter;
	logic [7:0] pixel;
	logic active;
	logic [sprite_slots-1:0] match;
	logic any_match;
	logic [slot_bits-1:0] first;

	// scan_done compares pixel 0 in its own cycle
	assign active = scan_done || state == m_run;
	assign pixel = scan_done ? 8'd0 : counter;

	always_comb begin
		for (int i = 0; i < sprite_slots; i++)
			match[i] = slot_valid[i] && !retire_slot[i] && slot_x[i] == pixel;	// Slot being retired is masked
		any_match = |match;
		first = '0;
		for (int i = sprite_slots - 1; i >= 0; i--) begin
			if (match[i])
				first = slot_bits'(i);
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= m_idle;
			counter <= '0;
			hit <= 1'b0;
			retire_slot <= '0;
			line_done <= 1'b0;
		end else begin
			hit <= 1'b0;
			retire_slot <= '0;
			line_done <= 1'b0;
			if (active) begin
				state <= m_run;
				if (any_match) begin
					// Counter holds so a tied X gets its turn next cycle
					hit <= 1'b1;
					retire_slot <= sprite_slots'(1) << first;
					counter <= pixel;
				end else if (pixel == 8'(line_pixels - 1)) begin
					state <= m_finished;
					line_done <= 1'b1;
				end else begin
					counter <= pixel + 8'd1;
				end
			end else if (state == m_finished) begin
				state <= m_idle;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (active && any_match) begin
			hit_index <= slot_index[first];
			hit_x <= pixel;
		end
	end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f flist.f \
	--top-module sprite_line_tb -Mdir obj_dir -o sprite_line_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_output=$(./obj_dir/sprite_line_sim 2>&1)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
	echo "Simulator exited with status $sim_status"
	exit 1
fi

if echo "$sim_output" | grep -q "Simulation PASSED"; then
	exit 0
fi
exit 1

// File: testbench/sprite_line_props.sv
`timescale 1ns/1ns

module sprite_line_props import sprite_pkg::*; (
		input logic                    clk,
		input logic                    reset,
		input logic                    hit,
		input logic                    line_done,
		input logic [sprite_slots-1:0] retire_slot,
		input logic [sprite_slots-1:0] slot_valid
	);

	int failures = 0;	// Counts failed assertions for the final verdict of the run

	hit_apart_from_line_done: assert property (
		@(posedge clk) disable iff (reset) !(hit && line_done))
		else begin
			failures++;
			$error("hit and line_done are high in the same cycle");
		end

	retire_is_one_hot: assert property (
		@(posedge clk) disable iff (reset) hit |-> $onehot(retire_slot))
		else begin
			failures++;
			$error("retire_slot is not one-hot while hit is high");
		end

	// The store drops the valid bit one cycle after the hit
	hit_slot_was_valid: assert property (
		@(posedge clk) disable iff (reset) hit |-> (retire_slot & slot_valid) == retire_slot)
		else begin
			failures++;
			$error("hit reported for a slot that is not valid");
		end

endmodule

bind sprite_x_matchers sprite_line_props i_sprite_line_props (
	.clk(clk),
	.reset(reset),
	.hit(hit),
	.line_done(line_done),
	.retire_slot(retire_slot),
	.slot_valid(slot_valid)
);

// File: testbench/sprite_line_tb.sv
`timescale 1ns/1ns

module sprite_line_tb import sprite_pkg::*; ();

	localparam int line_cycles = 43 + line_pixels + sprite_slots;
	localparam int lines_run = 11;
	localparam int margin_cycles = 1500;	// OAM writes and line setup

	logic clk;
	logic reset;
	logic cpu_we;
	logic [oam_addr_bits-1:0] cpu_addr;
	logic [7:0] cpu_wdata;
	logic [slot_bits-1:0] cpu_slot_sel;
	logic [7:0] cpu_slot_x;
	logic [7:0] line;
	logic tall;
	logic line_start;
	logic hit;
	logic [index_bits-1:0] hit_index;
	logic [7:0] hit_x;
	logic line_done;

	logic [7:0] model_y [oam_entries];
	logic [7:0] model_x [oam_entries];
	int exp_slot_x [sprite_slots];
	int exp_slot_count;
	int exp_hit_x [$];
	int exp_hit_index [$];
	int hit_cycle [$];
	int line_latency;
	int error_count;
	logic [31:0] lfsr_state;

	tb_clock i_tb_clock (
		.clk(clk),
		.reset(reset)
	);

	sprite_line_top i_sprite_line_top (
		.clk(clk),
		.reset(reset),
		.cpu_we(cpu_we),
		.cpu_addr(cpu_addr),
		.cpu_wdata(cpu_wdata),
		.cpu_slot_sel(cpu_slot_sel),
		.cpu_slot_x(cpu_slot_x),
		.line(line),
		.tall(tall),
		.line_start(line_start),
		.hit(hit),
		.hit_index(hit_index),
		.hit_x(hit_x),
		.line_done(line_done)
	);

	task automatic stop_run(input string why);
		error_count++;
		$display("%s", why);
		$display("Simulation FAILED");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic check_value(input string name, input int actual, input int expected);
		if (actual != expected)
			stop_run($sformatf("FAILED at %0t: %s is %0d, expected %0d",
				$time, name, actual, expected));
	endtask

	// Taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic random_bits(input int n, output int value);
		value = 0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			value = (value << 1) | int'(lfsr_state[0]);
		end
	endtask

	task automatic write_entry(input int entry, input int y, input int x);
		@(negedge clk);
		cpu_we = 1'b1;
		cpu_addr = oam_addr_bits'(entry * 2);
		cpu_wdata = 8'(y);
		@(negedge clk);
		cpu_addr = oam_addr_bits'(entry * 2 + 1);
		cpu_wdata = 8'(x);
		model_y[entry] = 8'(y);
		model_x[entry] = 8'(x);
	endtask

	// Y of 0 puts every line below the sprite
	task automatic hide_all_entries();
		for (int e = 0; e < oam_entries; e++)
			write_entry(e, 0, 0);
	endtask

	task automatic build_expected(input int ln, input bit tl);
		int row;
		int slot_obj [sprite_slots];
		exp_slot_count = 0;
		exp_hit_x.delete();
		exp_hit_index.delete();
		for (int e = 0; e < oam_entries; e++) begin
			row = ln + y_offset - int'(model_y[e]);
			if (row >= 0 && row < (tl ? 16 : 8) && exp_slot_count < sprite_slots) begin
				exp_slot_x[exp_slot_count] = int'(model_x[e]);
				slot_obj[exp_slot_count] = e;
				exp_slot_count++;
			end
		end
		for (int p = 0; p < line_pixels; p++) begin
			for (int s = 0; s < exp_slot_count; s++) begin
				if (exp_slot_x[s] == p) begin	// Ties go in slot order
					exp_hit_x.push_back(p);
					exp_hit_index.push_back(slot_obj[s]);
				end
			end
		end
	endtask

	task automatic run_line(input int ln, input bit tl, input bit readback);
		int cycles;
		int hits;
		build_expected(ln, tl);
		hit_cycle.delete();
		@(negedge clk);
		cpu_we = 1'b0;
		line = 8'(ln);
		tall = tl;
		line_start = 1'b1;
		@(negedge clk);
		line_start = 1'b0;
		cycles = 1;
		while (!i_sprite_line_top.scan_done && cycles < 100) begin
			@(negedge clk);
			cycles++;
		end
		check_value("line_start to scan_done cycles", cycles, 43);
		cpu_slot_sel = '0;
		cycles = 0;
		hits = 0;
		while (!line_done) begin
			@(negedge clk);
			cycles++;
			if (readback && cycles <= 16) begin
				check_value($sformatf("cpu_slot_x[%0d]", cycles - 1), int'(cpu_slot_x),
					cycles - 1 < exp_slot_count ? exp_slot_x[cycles - 1] : 255);
				cpu_slot_sel = slot_bits'(cycles);
			end
			if (hit) begin
				if (hits >= exp_hit_x.size()) begin
					stop_run($sformatf("Extra hit at pixel %0d for object %0d on line %0d",
						hit_x, hit_index, ln));
				end else begin
					check_value("hit_x", int'(hit_x), exp_hit_x[hits]);
					check_value("hit_index", int'(hit_index), exp_hit_index[hits]);
					hit_cycle.push_back(cycles);
					hits++;
				end
			end
		end
		check_value("hit count", hits, exp_hit_x.size());
		check_value("scan_done to line_done cycles", cycles, line_pixels + hits);
		line_latency = cycles;
	endtask

	task automatic check_idle_after_reset();
		for (int s = 0; s < 16; s++) begin
			cpu_slot_sel = slot_bits'(s);
			@(negedge clk);
			check_value($sformatf("cpu_slot_x[%0d]", s), int'(cpu_slot_x), 255);
			check_value("hit", int'(hit), 0);
			check_value("line_done", int'(line_done), 0);
		end
	endtask

	task automatic three_sprite_line();
		hide_all_entries();
		write_entry(5, 56, 90);	// Row 0
		write_entry(12, 53, 20);	// Row 3
		write_entry(20, 48, 60);	// Row 8 misses an 8 high sprite
		write_entry(30, 49, 150);
		run_line(40, 1'b0, 1'b0);
		check_value("hits on three sprite line", hit_cycle.size(), 3);
		check_value("line_done after scan_done", line_latency, 171);
	endtask

	task automatic equal_x_tie();
		hide_all_entries();
		write_entry(3, 76, 77);
		write_entry(8, 70, 77);
		run_line(60, 1'b0, 1'b0);
		check_value("tied hits", hit_cycle.size(), 2);
		check_value("cycles between tied hits", hit_cycle[1] - hit_cycle[0], 1);
		check_value("line_done after scan_done", line_latency, 170);
	endtask

	task automatic ten_sprite_limit();
		hide_all_entries();
		// X starts at 60 so readback ends before the first hit retires a slot
		for (int k = 0; k < 15; k++)
			write_entry(2 * k + 1, 116 - (k % 8), 60 + ((k * 7) % 15) * 6);
		run_line(100, 1'b0, 1'b1);
		check_value("hits with fifteen sprites", hit_cycle.size(), 10);
	endtask

	task automatic tall_sprite_rows();
		hide_all_entries();
		write_entry(0, 64, 30);	// Row 2
		write_entry(9, 56, 80);	// Row 10
		write_entry(17, 51, 120);	// Row 15
		write_entry(25, 50, 140);	// Row 16 misses both heights
		run_line(50, 1'b0, 1'b0);
		check_value("hits with 8 high sprites", hit_cycle.size(), 1);
		run_line(50, 1'b1, 1'b0);
		check_value("hits with 16 high sprites", hit_cycle.size(), 3);
	endtask

	task automatic random_lines();
		int ln;
		int tl;
		int r;
		int x;
		for (int n = 0; n < 6; n++) begin
			random_bits(7, ln);
			ln = ln + 10;
			random_bits(1, tl);
			for (int e = 0; e < oam_entries; e++) begin
				random_bits(5, r);
				random_bits(8, x);
				write_entry(e, (ln + y_offset + 4 - r) & 255, x);	// Rows -4 to 27
			end
			run_line(ln, tl[0], 1'b0);
		end
	endtask

	initial begin
		error_count = 0;
		lfsr_state = 32'hcde0;
		cpu_we = 1'b0;
		cpu_addr = '0;
		cpu_wdata = '0;
		cpu_slot_sel = '0;
		line = '0;
		tall = 1'b0;
		line_start = 1'b0;
		@(negedge reset);
		check_idle_after_reset();
		three_sprite_line();
		equal_x_tie();
		ten_sprite_limit();
		tall_sprite_rows();
		random_lines();
		if (error_count == 0 &&
			i_sprite_line_top.i_sprite_x_matchers.i_sprite_line_props.failures == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

	initial begin
		repeat (lines_run * line_cycles + margin_cycles) @(posedge clk);
		stop_run("Watchdog timeout: the tests did not finish in time");
	end

endmodule

// File: testbench/tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
		output logic clk,
		output logic reset
	);

	localparam int half_period = 10;

	initial begin
		clk = 1'b0;
		forever #half_period clk = ~clk;
	end

	// Reset covers the first two rising edges and drops on a falling edge
	initial begin
		reset = 1'b1;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule
